// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_ooo_core
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/core_pkg.sv
package core_pkg;

    // reorder buffer geometry
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    // architectural register file
    localparam int NUM_REGS = 16;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    localparam int DATA_W = 32;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // occupancy needs one extra bit to tell full from empty
    typedef logic [ROB_TAG_W:0] rob_cnt_t;

endpackage

// File: common/exec_pkg.sv
package exec_pkg;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_xor  = 3'd2,
        op_and  = 3'd3,
        op_load = 3'd4
    } op_t;

    // data memory behind the load unit
    localparam int MEM_WORDS = 16;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    localparam string MEM_INIT_FILE = "tb/load_mem.hex";

    // values of the arbiter's last winner bit
    localparam logic UNIT_ALU = 1'b0;
    localparam logic UNIT_LOAD = 1'b1;

endpackage

// File: hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  exec_pkg::op_t      dispatch_op,
    input  core_pkg::data_t    dispatch_a,
    input  core_pkg::data_t    dispatch_b,
    input  core_pkg::rob_tag_t dispatch_tag,
    input  logic               grant,
    output logic               req,
    output core_pkg::rob_tag_t req_tag,
    output core_pkg::data_t    req_data
);
    import core_pkg::*;
    import exec_pkg::*;

    logic accept;
    logic pop;
    data_t result;

    rob_tag_t wr_ptr;
    rob_tag_t rd_ptr;
    rob_cnt_t count;
    rob_tag_t q_tag [ROB_DEPTH];
    data_t q_data [ROB_DEPTH];

    assign accept = dispatch_valid && (dispatch_op != op_load);

    always_comb begin
        case (dispatch_op)
            op_add:  result = dispatch_a + dispatch_b;
            op_sub:  result = dispatch_a - dispatch_b;
            op_xor:  result = dispatch_a ^ dispatch_b;
            op_and:  result = dispatch_a & dispatch_b;
            default: result = '0;
        endcase
    end

    // head of the result queue sits on the bus request
    assign req = (count != '0);
    assign req_tag = q_tag[rd_ptr];
    assign req_data = q_data[rd_ptr];
    assign pop = req && grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (accept && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !accept) begin
                count <= count - 1'b1;
            end
        end
    end

    // result is registered straight into the queue
    always_ff @(posedge clk) begin
        if (accept) begin
            q_tag[wr_ptr] <= dispatch_tag;
            q_data[wr_ptr] <= result;
        end
    end

endmodule

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_req,
    input  core_pkg::rob_tag_t alu_tag,
    input  core_pkg::data_t    alu_data,
    input  logic               load_req,
    input  core_pkg::rob_tag_t load_tag,
    input  core_pkg::data_t    load_data,
    output logic               alu_grant,
    output logic               load_grant,
    output logic               cdb_valid,
    output core_pkg::rob_tag_t cdb_tag,
    output core_pkg::data_t    cdb_data
);
    import exec_pkg::*;

    logic last_winner;

    // on contention the unit that did not win last time goes first
    assign alu_grant = alu_req && (!load_req || (last_winner == UNIT_LOAD));
    assign load_grant = load_req && !alu_grant;

    assign cdb_valid = alu_grant || load_grant;
    assign cdb_tag = alu_grant ? alu_tag : load_tag;
    assign cdb_data = alu_grant ? alu_data : load_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_winner <= UNIT_LOAD;
        end else if (alu_grant) begin
            last_winner <= UNIT_ALU;
        end else if (load_grant) begin
            last_winner <= UNIT_LOAD;
        end
    end

endmodule

// File: hw/load_unit.sv
`timescale 1ns/1ps

module load_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  exec_pkg::op_t      dispatch_op,
    input  core_pkg::data_t    dispatch_a,
    input  core_pkg::data_t    dispatch_b,
    input  core_pkg::rob_tag_t dispatch_tag,
    input  logic               grant,
    output logic               req,
    output core_pkg::rob_tag_t req_tag,
    output core_pkg::data_t    req_data
);
    import core_pkg::*;
    import exec_pkg::*;

    data_t mem [MEM_WORDS];

    logic accept;
    logic pop;
    mem_addr_t addr;

    // stage one
    logic s1_valid;
    mem_addr_t s1_addr;
    rob_tag_t s1_tag;

    // result queue
    rob_tag_t wr_ptr;
    rob_tag_t rd_ptr;
    rob_cnt_t count;
    rob_tag_t q_tag [ROB_DEPTH];
    data_t q_data [ROB_DEPTH];

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    assign accept = dispatch_valid && (dispatch_op == op_load);

    // word address wraps inside the small memory
    assign addr = mem_addr_t'(dispatch_a + dispatch_b);

    assign req = (count != '0);
    assign req_tag = q_tag[rd_ptr];
    assign req_data = q_data[rd_ptr];
    assign pop = req && grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            s1_valid <= accept;
            if (s1_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (s1_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !s1_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= addr;
        s1_tag <= dispatch_tag;
        if (s1_valid) begin
            q_tag[wr_ptr] <= s1_tag;
            q_data[wr_ptr] <= mem[s1_addr];
        end
    end

endmodule

// File: hw/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  exec_pkg::op_t      dispatch_op,
    input  core_pkg::reg_idx_t dispatch_rd,
    input  core_pkg::data_t    dispatch_a,
    input  core_pkg::data_t    dispatch_b,
    input  core_pkg::reg_idx_t read_addr,
    output core_pkg::rob_tag_t dispatch_tag,
    output logic               credit_return,
    output logic               commit_valid,
    output core_pkg::reg_idx_t commit_rd,
    output core_pkg::rob_tag_t commit_tag,
    output core_pkg::data_t    commit_data,
    output core_pkg::data_t    read_data,
    output logic               read_busy
);
    import core_pkg::*;

    logic alu_req;
    logic alu_grant;
    rob_tag_t alu_tag;
    data_t alu_data;

    logic load_req;
    logic load_grant;
    rob_tag_t load_tag;
    data_t load_data;

    logic cdb_valid;
    rob_tag_t cdb_tag;
    data_t cdb_data;

    reorder_buffer u_rob (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_rd(dispatch_rd),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data),
        .dispatch_tag(dispatch_tag),
        .commit_valid(commit_valid),
        .commit_rd(commit_rd),
        .commit_tag(commit_tag),
        .commit_data(commit_data),
        .credit_return(credit_return)
    );

    alu_unit u_alu (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_a(dispatch_a),
        .dispatch_b(dispatch_b),
        .dispatch_tag(dispatch_tag),
        .grant(alu_grant),
        .req(alu_req),
        .req_tag(alu_tag),
        .req_data(alu_data)
    );

    load_unit u_load (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_a(dispatch_a),
        .dispatch_b(dispatch_b),
        .dispatch_tag(dispatch_tag),
        .grant(load_grant),
        .req(load_req),
        .req_tag(load_tag),
        .req_data(load_data)
    );

    cdb_arbiter u_arb (
        .clk(clk),
        .rst(rst),
        .alu_req(alu_req),
        .alu_tag(alu_tag),
        .alu_data(alu_data),
        .load_req(load_req),
        .load_tag(load_tag),
        .load_data(load_data),
        .alu_grant(alu_grant),
        .load_grant(load_grant),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data)
    );

    reg_file u_regs (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_rd(dispatch_rd),
        .dispatch_tag(dispatch_tag),
        .commit_valid(commit_valid),
        .commit_rd(commit_rd),
        .commit_tag(commit_tag),
        .commit_data(commit_data),
        .read_addr(read_addr),
        .read_data(read_data),
        .read_busy(read_busy)
    );

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  core_pkg::reg_idx_t dispatch_rd,
    input  core_pkg::rob_tag_t dispatch_tag,
    input  logic               commit_valid,
    input  core_pkg::reg_idx_t commit_rd,
    input  core_pkg::rob_tag_t commit_tag,
    input  core_pkg::data_t    commit_data,
    input  core_pkg::reg_idx_t read_addr,
    output core_pkg::data_t    read_data,
    output logic               read_busy
);
    import core_pkg::*;

    data_t regs [NUM_REGS];
    rob_tag_t tags [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    assign read_data = regs[read_addr];
    assign read_busy = busy[read_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_valid) begin
                regs[commit_rd] <= commit_data;
                // only the newest producer may release the register
                if (busy[commit_rd] && (tags[commit_rd] == commit_tag)) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            // a rename in the same cycle wins over the clear above
            if (dispatch_valid) begin
                busy[dispatch_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            tags[dispatch_rd] <= dispatch_tag;
        end
    end

endmodule

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  core_pkg::reg_idx_t dispatch_rd,
    input  logic               cdb_valid,
    input  core_pkg::rob_tag_t cdb_tag,
    input  core_pkg::data_t    cdb_data,
    output core_pkg::rob_tag_t dispatch_tag,
    output logic               commit_valid,
    output core_pkg::reg_idx_t commit_rd,
    output core_pkg::rob_tag_t commit_tag,
    output core_pkg::data_t    commit_data,
    output logic               credit_return
);
    import core_pkg::*;

    // head and tail wrap on their own since depth is a power of two
    rob_tag_t head;
    rob_tag_t tail;
    rob_cnt_t count;

    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] ready;
    reg_idx_t entry_rd [ROB_DEPTH];
    data_t entry_data [ROB_DEPTH];

    logic alloc;
    logic retire;

    // new entry always lands at the tail
    assign dispatch_tag = tail;

    // a full buffer takes no new entry
    assign alloc = dispatch_valid && (count != rob_cnt_t'(ROB_DEPTH));
    assign retire = busy[head] && ready[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            busy <= '0;
            ready <= '0;
            commit_valid <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            commit_valid <= retire;
            credit_return <= retire;

            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end

            if (retire) begin
                busy[head] <= 1'b0;
                ready[head] <= 1'b0;
                head <= head + 1'b1;
            end

            if (alloc) begin
                busy[tail] <= 1'b1;
                ready[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end

            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry payload and commit payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_rd[tail] <= dispatch_rd;
        end
        if (cdb_valid) begin
            entry_data[cdb_tag] <= cdb_data;
        end
        if (retire) begin
            commit_rd <= entry_rd[head];
            commit_tag <= head;
            commit_data <= entry_data[head];
        end
    end

endmodule

// File: sources.f
common/core_pkg.sv
common/exec_pkg.sv
rob/reorder_buffer.sv
hw/alu_unit.sv
hw/load_unit.sv
hw/cdb_arbiter.sv
hw/reg_file.sv
hw/ooo_core_top.sv
+incdir+tb
tb/tb_ooo_core.sv

// File: tb/load_mem.hex
// one 32-bit data memory word per line, addresses 0 to 15
c0de00ff
c0de11ee
c0de22dd
c0de33cc
c0de44bb
c0de55aa
c0de6699
c0de7788
c0de8877
c0de9966
c0deaa55
c0debb44
c0decc33
c0dedd22
c0deee11
c0deff00

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per operation with its test group, op, rd, a and b
// the expected column is worked out once the memory image is read
localparam int NUM_ROWS = 21;
localparam int NUM_GROUPS = 4;

// groups 0 and 1 get random idle cycles between dispatches
localparam logic [NUM_GROUPS-1:0] GROUP_GAPS = 4'b0011;

int row_group [NUM_ROWS];
op_t row_op [NUM_ROWS];
reg_idx_t row_rd [NUM_ROWS];
data_t row_a [NUM_ROWS];
data_t row_b [NUM_ROWS];
data_t row_exp [NUM_ROWS];

function automatic string group_name(input int g);
    case (g)
        0: return "alu ops";
        1: return "loads";
        2: return "mixed burst";
        default: return "same register";
    endcase
endfunction

task automatic put_row(input int i, input int g, input op_t op, input reg_idx_t rd,
                       input data_t a, input data_t b);
    row_group[i] = g;
    row_op[i] = op;
    row_rd[i] = rd;
    row_a[i] = a;
    row_b[i] = b;
endtask

task automatic fill_table();
    put_row(0, 0, op_add, 4'd1, 32'd5, 32'd7);
    put_row(1, 0, op_sub, 4'd2, 32'd3, 32'd10);
    put_row(2, 0, op_xor, 4'd3, 32'hf0f0_1234, 32'h0ff0_4321);
    put_row(3, 0, op_and, 4'd4, 32'hdead_beef, 32'h0f0f_ff00);
    // load address is the low four bits of a + b
    put_row(4, 1, op_load, 4'd5, 32'd2, 32'd3);
    put_row(5, 1, op_load, 4'd6, 32'h10, 32'd1);
    put_row(6, 1, op_load, 4'd7, 32'hffff_fff0, 32'hf);
    // dispatched back to back so tags wrap past 7
    put_row(7, 2, op_add, 4'd8, 32'd100, 32'd23);
    put_row(8, 2, op_load, 4'd10, 32'd6, 32'd4);
    put_row(9, 2, op_xor, 4'd11, 32'haaaa_5555, 32'h1234_5678);
    put_row(10, 2, op_load, 4'd12, 32'd9, 32'd9);
    put_row(11, 2, op_sub, 4'd13, 32'd0, 32'd1);
    put_row(12, 2, op_and, 4'd14, 32'hffff_0000, 32'h1357_9bdf);
    put_row(13, 2, op_load, 4'd15, 32'd12, 32'd0);
    put_row(14, 2, op_add, 4'd0, 32'h7fff_ffff, 32'd1);
    put_row(15, 2, op_load, 4'd1, 32'd3, 32'd5);
    put_row(16, 2, op_xor, 4'd2, 32'd77, 32'd77);
    // younger write to the same register goes out before the older one commits
    put_row(17, 3, op_load, 4'd9, 32'd7, 32'd3);
    put_row(18, 3, op_add, 4'd9, 32'd40, 32'd2);
    put_row(19, 3, op_add, 4'd6, 32'd1000, 32'd24);
    put_row(20, 3, op_load, 4'd6, 32'd11, 32'd2);
endtask

`endif

// File: tb/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
    import core_pkg::*;
    import exec_pkg::*;

    `include "tb_vectors.svh"

    localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 200;

    logic clk;
    logic rst;
    logic dispatch_valid;
    op_t dispatch_op;
    reg_idx_t dispatch_rd;
    data_t dispatch_a;
    data_t dispatch_b;
    reg_idx_t read_addr;
    rob_tag_t dispatch_tag;
    logic credit_return;
    logic commit_valid;
    reg_idx_t commit_rd;
    rob_tag_t commit_tag;
    data_t commit_data;
    data_t read_data;
    logic read_busy;

    data_t mem_image [MEM_WORDS];
    data_t shadow [NUM_REGS];
    int sb_row [$];
    int sb_seq [$];
    int credits;
    int cycles;
    int seq;
    int n_commits;
    int n_returns;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    logic [31:0] lfsr;

    ooo_core_top dut_i (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_rd(dispatch_rd),
        .dispatch_a(dispatch_a),
        .dispatch_b(dispatch_b),
        .read_addr(read_addr),
        .dispatch_tag(dispatch_tag),
        .credit_return(credit_return),
        .commit_valid(commit_valid),
        .commit_rd(commit_rd),
        .commit_tag(commit_tag),
        .commit_data(commit_data),
        .read_data(read_data),
        .read_busy(read_busy)
    );

    always #10 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'ha300_0000;
        end
        return b;
    endfunction

    function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
        mem_addr_t addr;
        addr = mem_addr_t'(a + b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_and:  return a & b;
            op_load: return mem_image[addr];
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // one clock sampled on the falling edge where outputs are settled
    task automatic tick();
        int row;
        int s;
        @(negedge clk);
        if (credit_return) begin
            credits++;
            n_returns++;
        end
        if (commit_valid) begin
            n_commits++;
            if (sb_row.size() == 0) begin
                $display("Error at %0t ns: commit seen with no operation outstanding", $time);
                errors++;
                test_errors++;
            end else begin
                row = sb_row.pop_front();
                s = sb_seq.pop_front();
                check_value("commit_rd", 32'(commit_rd), 32'(row_rd[row]));
                check_value("commit_tag", 32'(commit_tag), 32'(s % ROB_DEPTH));
                check_value("commit_data", commit_data, row_exp[row]);
                shadow[row_rd[row]] = row_exp[row];
            end
        end
    endtask

    task automatic dispatch_row(input int row);
        while (credits == 0) begin
            tick();
        end
        check_value("dispatch_tag", 32'(dispatch_tag), 32'(seq % ROB_DEPTH));
        dispatch_valid = 1'b1;
        dispatch_op = row_op[row];
        dispatch_rd = row_rd[row];
        dispatch_a = row_a[row];
        dispatch_b = row_b[row];
        credits--;
        sb_row.push_back(row);
        sb_seq.push_back(seq);
        seq++;
        tick();
        dispatch_valid = 1'b0;
    endtask

    task automatic idle_gap();
        int n;
        n = 0;
        repeat (2) begin
            n = (n << 1) | int'(lfsr_bit());
        end
        repeat (n) begin
            tick();
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // watchdog on the cycle count
    initial begin
        cycles = 0;
        repeat (CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles, %0d commits still outstanding",
                 cycles, sb_row.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int g;
        int r;
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_rd = '0;
        dispatch_a = '0;
        dispatch_b = '0;
        read_addr = '0;
        lfsr = 32'h30d3_65c5;
        credits = ROB_DEPTH;
        seq = 0;
        n_commits = 0;
        n_returns = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        $readmemh(MEM_INIT_FILE, mem_image);
        fill_table();
        for (r = 0; r < NUM_ROWS; r++) begin
            row_exp[r] = model_result(row_op[r], row_a[r], row_b[r]);
        end
        for (r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("commit_valid after reset", 32'(commit_valid), 32'd0);
        check_value("credit_return after reset", 32'(credit_return), 32'd0);

        for (g = 0; g < NUM_GROUPS; g++) begin
            for (r = 0; r < NUM_ROWS; r++) begin
                if (row_group[r] == g) begin
                    dispatch_row(r);
                    if (GROUP_GAPS[g]) begin
                        idle_gap();
                    end
                end
            end
            while (sb_row.size() != 0) begin
                tick();
            end
            finish_test(group_name(g));
        end

        // every dispatch comes back as one commit and one credit
        check_value("commit count", n_commits, seq);
        check_value("credit return count", n_returns, n_commits);
        check_value("credits held after drain", credits, ROB_DEPTH);
        finish_test("credit accounting");

        for (r = 0; r < NUM_REGS; r++) begin
            read_addr = reg_idx_t'(r);
            tick();
            check_value($sformatf("read_data of r%0d", r), read_data, shadow[r]);
            check_value($sformatf("read_busy of r%0d", r), 32'(read_busy), 32'd0);
        end
        finish_test("register readback");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
